// ==== src/axi_pkg.sv ====
package axi_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_LEN_W  = 8;
  localparam int AXI_SIZE_W = 3;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_LEN_W-1:0]  len;
    logic [AXI_SIZE_W-1:0] size;
    logic [1:0]            burst;
  } axi_aw_t;

  // Read address carries the same fields as write address
  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [1:0]          resp;
    logic [AXI_ID_W-1:0] id;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
    logic [AXI_ID_W-1:0]   id;
  } axi_r_t;

endpackage

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

  localparam int CPU_WIDTH       = 32;
  localparam int LSU_OPT_WIDTH   = 4;
  localparam int MEM_DEPTH_WORDS = 256;

  // Bit 0 set marks a store
  typedef enum logic [LSU_OPT_WIDTH-1:0] {
    LSU_NOP = 4'b0000,
    LSU_LB  = 4'b0010,
    LSU_LH  = 4'b0100,
    LSU_LW  = 4'b0110,
    LSU_LBU = 4'b1000,
    LSU_LHU = 4'b1010,
    LSU_SB  = 4'b0001,
    LSU_SH  = 4'b0011,
    LSU_SW  = 4'b0101
  } lsu_op_e;

  typedef struct packed {
    lsu_op_e              opt;
    logic [CPU_WIDTH-1:0] addr;
    logic [CPU_WIDTH-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [CPU_WIDTH-1:0] data;
  } lsu_rsp_t;

endpackage

// ==== src/lsu.sv ====
`timescale 1ns/1ps

module lsu
  import axi_pkg::*;
  import lsu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  lsu_req_t i_lsu_req,
  input  logic     i_lsu_valid,
  output logic     o_lsu_ready,
  output lsu_rsp_t o_lsu_rsp,
  output logic     o_lsu_post_valid,
  input  logic     i_lsu_post_ready,
  output axi_aw_t  o_aw,
  output logic     o_aw_valid,
  input  logic     i_aw_ready,
  output axi_w_t   o_w,
  output logic     o_w_valid,
  input  logic     i_w_ready,
  input  axi_b_t   i_b,
  input  logic     i_b_valid,
  output logic     o_b_ready,
  output axi_ar_t  o_ar,
  output logic     o_ar_valid,
  input  logic     i_ar_ready,
  input  axi_r_t   i_r,
  input  logic     i_r_valid,
  output logic     o_r_ready
);

  typedef enum logic [2:0] {
    ST_INIT,
    ST_IDLE,
    ST_WR,
    ST_RD,
    ST_RESP
  } state_e;

  state_e                state;
  state_e                state_next;
  logic                  accept;
  logic                  store_req;
  logic                  nop_req;
  logic                  done_now;
  logic                  aw_pend;
  logic                  w_pend;
  logic                  ar_pend;
  logic [AXI_SIZE_W-1:0] size_d;
  logic [AXI_STRB_W-1:0] mask_d;
  lsu_op_e               opt_q;
  logic [CPU_WIDTH-1:0]  addr_q;
  logic [AXI_SIZE_W-1:0] size_q;
  logic [AXI_STRB_W-1:0] strb_q;
  logic [AXI_DATA_W-1:0] wdata_q;
  logic [CPU_WIDTH-1:0]  rdata_sh;
  logic [CPU_WIDTH-1:0]  load_ext;
  logic [CPU_WIDTH-1:0]  rsp_now;
  logic [CPU_WIDTH-1:0]  rsp_q;

  assign store_req   = i_lsu_req.opt[0];
  assign nop_req     = (i_lsu_req.opt == LSU_NOP);
  assign o_lsu_ready = (state == ST_IDLE);
  assign accept      = o_lsu_ready && i_lsu_valid;

  // Access size and byte mask
  always_comb begin
    case (i_lsu_req.opt)
      LSU_LB, LSU_LBU, LSU_SB: begin
        size_d = 3'd0;
        mask_d = 4'b0001;
      end
      LSU_LH, LSU_LHU, LSU_SH: begin
        size_d = 3'd1;
        mask_d = 4'b0011;
      end
      default: begin
        size_d = 3'd2;
        mask_d = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      opt_q   <= i_lsu_req.opt;
      addr_q  <= i_lsu_req.addr;
      size_q  <= size_d;
      strb_q  <= mask_d << i_lsu_req.addr[1:0];
      wdata_q <= i_lsu_req.wdata << {i_lsu_req.addr[1:0], 3'b000};
      rsp_q   <= '0;
    end else if (done_now) begin
      rsp_q <= rsp_now;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= ST_INIT;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      ar_pend <= 1'b0;
    end else begin
      state   <= state_next;
      aw_pend <= (accept && store_req) || (aw_pend && !i_aw_ready);
      w_pend  <= (accept && store_req) || (w_pend && !i_w_ready);
      ar_pend <= (accept && !store_req && !nop_req) || (ar_pend && !i_ar_ready);
    end
  end

  assign done_now = ((state == ST_WR) && i_b_valid) ||
                    ((state == ST_RD) && i_r_valid && i_r.last);

  always_comb begin
    state_next = state;
    case (state)
      ST_INIT: state_next = ST_IDLE;
      ST_IDLE: begin
        if (i_lsu_valid) begin
          if (nop_req) begin
            state_next = ST_RESP;
          end else if (store_req) begin
            state_next = ST_WR;
          end else begin
            state_next = ST_RD;
          end
        end
      end
      ST_WR, ST_RD: begin
        if (done_now) begin
          state_next = i_lsu_post_ready ? ST_IDLE : ST_RESP;
        end
      end
      ST_RESP: begin
        if (i_lsu_post_ready) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  assign o_aw = '{addr: addr_q, id: '0, len: '0, size: size_q, burst: AXI_BURST_INCR};
  assign o_ar = o_aw;
  assign o_w  = '{data: wdata_q, strb: strb_q, last: 1'b1};

  assign o_aw_valid = aw_pend;
  assign o_w_valid  = w_pend;
  assign o_ar_valid = ar_pend;
  assign o_b_ready  = (state == ST_WR);
  assign o_r_ready  = (state == ST_RD);

  // Bring the addressed lane down to bit 0
  assign rdata_sh = i_r.data >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (opt_q)
      LSU_LB:  load_ext = {{(CPU_WIDTH - 8){rdata_sh[7]}}, rdata_sh[7:0]};
      LSU_LH:  load_ext = {{(CPU_WIDTH - 16){rdata_sh[15]}}, rdata_sh[15:0]};
      LSU_LBU: load_ext = {{(CPU_WIDTH - 8){1'b0}}, rdata_sh[7:0]};
      LSU_LHU: load_ext = {{(CPU_WIDTH - 16){1'b0}}, rdata_sh[15:0]};
      default: load_ext = rdata_sh;
    endcase
  end

  // Stores answer with zero
  assign rsp_now = (state == ST_RD) ? load_ext : '0;

  assign o_lsu_rsp.data   = (state == ST_RESP) ? rsp_q : rsp_now;
  assign o_lsu_post_valid = done_now || (state == ST_RESP);

endmodule

// ==== src/ifu.sv ====
`timescale 1ns/1ps

module ifu
  import axi_pkg::*;
  import lsu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic [CPU_WIDTH-1:0] i_pc,
  input  logic                 i_fetch_valid,
  output logic                 o_fetch_ready,
  output logic [CPU_WIDTH-1:0] o_instr,
  output logic                 o_instr_valid,
  input  logic                 i_instr_ready,
  output axi_ar_t              o_ar,
  output logic                 o_ar_valid,
  input  logic                 i_ar_ready,
  input  axi_r_t               i_r,
  input  logic                 i_r_valid,
  output logic                 o_r_ready
);

  typedef enum logic [1:0] {
    ST_INIT,
    ST_IDLE,
    ST_BUSY,
    ST_HOLD
  } state_e;

  state_e               state;
  logic                 accept;
  logic                 r_done;
  logic                 ar_pend;
  logic [CPU_WIDTH-1:0] pc_q;
  logic [CPU_WIDTH-1:0] instr_q;

  assign o_fetch_ready = (state == ST_IDLE);
  assign accept        = o_fetch_ready && i_fetch_valid;
  assign r_done        = (state == ST_BUSY) && i_r_valid && i_r.last;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      pc_q <= {i_pc[CPU_WIDTH-1:2], 2'b00};
    end
    if (r_done) begin
      instr_q <= i_r.data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= ST_INIT;
      ar_pend <= 1'b0;
    end else begin
      ar_pend <= accept || (ar_pend && !i_ar_ready);
      case (state)
        ST_INIT: state <= ST_IDLE;
        ST_IDLE: if (i_fetch_valid) state <= ST_BUSY;
        ST_BUSY: if (r_done) state <= i_instr_ready ? ST_IDLE : ST_HOLD;
        default: if (i_instr_ready) state <= ST_IDLE;
      endcase
    end
  end

  // One full word per fetch
  assign o_ar = '{addr: pc_q, id: '0, len: '0, size: AXI_SIZE_W'($clog2(CPU_WIDTH / 8)),
                  burst: AXI_BURST_INCR};
  assign o_ar_valid = ar_pend;
  assign o_r_ready  = (state == ST_BUSY);

  assign o_instr       = (state == ST_HOLD) ? instr_q : i_r.data;
  assign o_instr_valid = r_done || (state == ST_HOLD);

endmodule

// ==== src/axi_arbiter.sv ====
`timescale 1ns/1ps

module axi_arbiter
  import axi_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  axi_aw_t i_s0_aw,
  input  logic    i_s0_aw_valid,
  output logic    o_s0_aw_ready,
  input  axi_w_t  i_s0_w,
  input  logic    i_s0_w_valid,
  output logic    o_s0_w_ready,
  output axi_b_t  o_s0_b,
  output logic    o_s0_b_valid,
  input  logic    i_s0_b_ready,
  input  axi_ar_t i_s0_ar,
  input  logic    i_s0_ar_valid,
  output logic    o_s0_ar_ready,
  output axi_r_t  o_s0_r,
  output logic    o_s0_r_valid,
  input  logic    i_s0_r_ready,
  input  axi_ar_t i_s1_ar,
  input  logic    i_s1_ar_valid,
  output logic    o_s1_ar_ready,
  output axi_r_t  o_s1_r,
  output logic    o_s1_r_valid,
  input  logic    i_s1_r_ready,
  output axi_aw_t o_m_aw,
  output logic    o_m_aw_valid,
  input  logic    i_m_aw_ready,
  output axi_w_t  o_m_w,
  output logic    o_m_w_valid,
  input  logic    i_m_w_ready,
  input  axi_b_t  i_m_b,
  input  logic    i_m_b_valid,
  output logic    o_m_b_ready,
  output axi_ar_t o_m_ar,
  output logic    o_m_ar_valid,
  input  logic    i_m_ar_ready,
  input  axi_r_t  i_m_r,
  input  logic    i_m_r_valid,
  output logic    o_m_r_ready
);

  logic       busy;
  logic       owner;
  logic       last_winner;
  logic       pick;
  logic       sel;
  logic [1:0] rd_gnt;
  logic       r_to_s1;
  axi_r_t     r_local;

  // Alternate when both masters ask
  assign pick = (i_s0_ar_valid && i_s1_ar_valid) ? !last_winner : i_s1_ar_valid;
  assign sel  = busy ? owner : pick;

  assign rd_gnt[0] = !sel && (busy || i_s0_ar_valid);
  assign rd_gnt[1] = sel && (busy || i_s1_ar_valid);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy        <= 1'b0;
      owner       <= 1'b0;
      last_winner <= 1'b1;
    end else if (!busy && (|rd_gnt)) begin
      busy        <= 1'b1;
      owner       <= sel;
      last_winner <= sel;
    end else if (busy && i_m_r_valid && o_m_r_ready && i_m_r.last) begin
      busy <= 1'b0;
    end
  end

  // Master index goes into the top ID bit
  always_comb begin
    o_m_ar = sel ? i_s1_ar : i_s0_ar;
    o_m_ar.id[AXI_ID_W-1] = o_m_ar.id[AXI_ID_W-1] | sel;
  end

  assign o_m_ar_valid  = (rd_gnt[0] && i_s0_ar_valid) || (rd_gnt[1] && i_s1_ar_valid);
  assign o_s0_ar_ready = rd_gnt[0] && i_m_ar_ready;
  assign o_s1_ar_ready = rd_gnt[1] && i_m_ar_ready;

  assign r_to_s1 = i_m_r.id[AXI_ID_W-1];

  always_comb begin
    r_local = i_m_r;
    r_local.id[AXI_ID_W-1] = 1'b0;
  end

  assign o_s0_r       = r_local;
  assign o_s1_r       = r_local;
  assign o_s0_r_valid = i_m_r_valid && !r_to_s1;
  assign o_s1_r_valid = i_m_r_valid && r_to_s1;
  assign o_m_r_ready  = r_to_s1 ? i_s1_r_ready : i_s0_r_ready;

  // Only the lsu writes
  assign o_m_aw        = i_s0_aw;
  assign o_m_aw_valid  = i_s0_aw_valid;
  assign o_s0_aw_ready = i_m_aw_ready;
  assign o_m_w         = i_s0_w;
  assign o_m_w_valid   = i_s0_w_valid;
  assign o_s0_w_ready  = i_m_w_ready;
  assign o_s0_b        = i_m_b;
  assign o_s0_b_valid  = i_m_b_valid;
  assign o_m_b_ready   = i_s0_b_ready;

endmodule

// ==== src/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram
  import axi_pkg::*;
  import lsu_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  axi_aw_t i_aw,
  input  logic    i_aw_valid,
  output logic    o_aw_ready,
  input  axi_w_t  i_w,
  input  logic    i_w_valid,
  output logic    o_w_ready,
  output axi_b_t  o_b,
  output logic    o_b_valid,
  input  logic    i_b_ready,
  input  axi_ar_t i_ar,
  input  logic    i_ar_valid,
  output logic    o_ar_ready,
  output axi_r_t  o_r,
  output logic    o_r_valid,
  input  logic    i_r_ready
);

  localparam int IDX_W = $clog2(MEM_DEPTH_WORDS);

  logic [AXI_DATA_W-1:0] mem [MEM_DEPTH_WORDS];

  axi_aw_t               aw_q;
  axi_w_t                w_q;
  logic                  aw_held;
  logic                  w_held;
  logic                  do_write;
  logic                  ar_hs;
  logic [IDX_W-1:0]      w_idx;
  logic [IDX_W-1:0]      r_idx;
  logic [AXI_ID_W-1:0]   b_id_q;
  logic [AXI_ID_W-1:0]   r_id_q;
  logic [AXI_DATA_W-1:0] r_data_q;

  // No new write until the previous B is taken
  assign o_aw_ready = !aw_held && !o_b_valid;
  assign o_w_ready  = !w_held && !o_b_valid;
  assign o_ar_ready = !o_r_valid;

  assign do_write = aw_held && w_held;
  assign ar_hs    = i_ar_valid && o_ar_ready;
  assign w_idx    = aw_q.addr[2 +: IDX_W];
  assign r_idx    = i_ar.addr[2 +: IDX_W];

  always_ff @(posedge i_clk) begin
    if (i_aw_valid && o_aw_ready) begin
      aw_q <= i_aw;
    end
    if (i_w_valid && o_w_ready) begin
      w_q <= i_w;
    end
    if (do_write) begin
      for (int i = 0; i < AXI_STRB_W; i++) begin
        if (w_q.strb[i]) begin
          mem[w_idx][8*i +: 8] <= w_q.data[8*i +: 8];
        end
      end
      b_id_q <= aw_q.id;
    end
    if (ar_hs) begin
      r_data_q <= mem[r_idx];
      r_id_q   <= i_ar.id;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      aw_held   <= 1'b0;
      w_held    <= 1'b0;
      o_b_valid <= 1'b0;
      o_r_valid <= 1'b0;
    end else begin
      aw_held   <= (aw_held || (i_aw_valid && o_aw_ready)) && !do_write;
      w_held    <= (w_held || (i_w_valid && o_w_ready)) && !do_write;
      o_b_valid <= do_write || (o_b_valid && !i_b_ready);
      o_r_valid <= ar_hs || (o_r_valid && !i_r_ready);
    end
  end

  assign o_b = '{resp: AXI_RESP_OKAY, id: b_id_q};
  assign o_r = '{data: r_data_q, resp: AXI_RESP_OKAY, last: 1'b1, id: r_id_q};

endmodule

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top
  import axi_pkg::*;
  import lsu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  lsu_req_t             i_lsu_req,
  input  logic                 i_lsu_valid,
  output logic                 o_lsu_ready,
  output lsu_rsp_t             o_lsu_rsp,
  output logic                 o_lsu_post_valid,
  input  logic                 i_lsu_post_ready,
  input  logic [CPU_WIDTH-1:0] i_pc,
  input  logic                 i_fetch_valid,
  output logic                 o_fetch_ready,
  output logic [CPU_WIDTH-1:0] o_instr,
  output logic                 o_instr_valid,
  input  logic                 i_instr_ready
);

  // lsu link
  axi_aw_t lsu_aw;
  logic    lsu_aw_valid;
  logic    lsu_aw_ready;
  axi_w_t  lsu_w;
  logic    lsu_w_valid;
  logic    lsu_w_ready;
  axi_b_t  lsu_b;
  logic    lsu_b_valid;
  logic    lsu_b_ready;
  axi_ar_t lsu_ar;
  logic    lsu_ar_valid;
  logic    lsu_ar_ready;
  axi_r_t  lsu_r;
  logic    lsu_r_valid;
  logic    lsu_r_ready;

  // ifu link, reads only
  axi_ar_t ifu_ar;
  logic    ifu_ar_valid;
  logic    ifu_ar_ready;
  axi_r_t  ifu_r;
  logic    ifu_r_valid;
  logic    ifu_r_ready;

  // Arbiter to SRAM
  axi_aw_t mem_aw;
  logic    mem_aw_valid;
  logic    mem_aw_ready;
  axi_w_t  mem_w;
  logic    mem_w_valid;
  logic    mem_w_ready;
  axi_b_t  mem_b;
  logic    mem_b_valid;
  logic    mem_b_ready;
  axi_ar_t mem_ar;
  logic    mem_ar_valid;
  logic    mem_ar_ready;
  axi_r_t  mem_r;
  logic    mem_r_valid;
  logic    mem_r_ready;

  lsu u_lsu (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_lsu_req       (i_lsu_req),
    .i_lsu_valid     (i_lsu_valid),
    .o_lsu_ready     (o_lsu_ready),
    .o_lsu_rsp       (o_lsu_rsp),
    .o_lsu_post_valid(o_lsu_post_valid),
    .i_lsu_post_ready(i_lsu_post_ready),
    .o_aw            (lsu_aw),
    .o_aw_valid      (lsu_aw_valid),
    .i_aw_ready      (lsu_aw_ready),
    .o_w             (lsu_w),
    .o_w_valid       (lsu_w_valid),
    .i_w_ready       (lsu_w_ready),
    .i_b             (lsu_b),
    .i_b_valid       (lsu_b_valid),
    .o_b_ready       (lsu_b_ready),
    .o_ar            (lsu_ar),
    .o_ar_valid      (lsu_ar_valid),
    .i_ar_ready      (lsu_ar_ready),
    .i_r             (lsu_r),
    .i_r_valid       (lsu_r_valid),
    .o_r_ready       (lsu_r_ready)
  );

  ifu u_ifu (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pc         (i_pc),
    .i_fetch_valid(i_fetch_valid),
    .o_fetch_ready(o_fetch_ready),
    .o_instr      (o_instr),
    .o_instr_valid(o_instr_valid),
    .i_instr_ready(i_instr_ready),
    .o_ar         (ifu_ar),
    .o_ar_valid   (ifu_ar_valid),
    .i_ar_ready   (ifu_ar_ready),
    .i_r          (ifu_r),
    .i_r_valid    (ifu_r_valid),
    .o_r_ready    (ifu_r_ready)
  );

  axi_arbiter u_axi_arbiter (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_s0_aw      (lsu_aw),
    .i_s0_aw_valid(lsu_aw_valid),
    .o_s0_aw_ready(lsu_aw_ready),
    .i_s0_w       (lsu_w),
    .i_s0_w_valid (lsu_w_valid),
    .o_s0_w_ready (lsu_w_ready),
    .o_s0_b       (lsu_b),
    .o_s0_b_valid (lsu_b_valid),
    .i_s0_b_ready (lsu_b_ready),
    .i_s0_ar      (lsu_ar),
    .i_s0_ar_valid(lsu_ar_valid),
    .o_s0_ar_ready(lsu_ar_ready),
    .o_s0_r       (lsu_r),
    .o_s0_r_valid (lsu_r_valid),
    .i_s0_r_ready (lsu_r_ready),
    .i_s1_ar      (ifu_ar),
    .i_s1_ar_valid(ifu_ar_valid),
    .o_s1_ar_ready(ifu_ar_ready),
    .o_s1_r       (ifu_r),
    .o_s1_r_valid (ifu_r_valid),
    .i_s1_r_ready (ifu_r_ready),
    .o_m_aw       (mem_aw),
    .o_m_aw_valid (mem_aw_valid),
    .i_m_aw_ready (mem_aw_ready),
    .o_m_w        (mem_w),
    .o_m_w_valid  (mem_w_valid),
    .i_m_w_ready  (mem_w_ready),
    .i_m_b        (mem_b),
    .i_m_b_valid  (mem_b_valid),
    .o_m_b_ready  (mem_b_ready),
    .o_m_ar       (mem_ar),
    .o_m_ar_valid (mem_ar_valid),
    .i_m_ar_ready (mem_ar_ready),
    .i_m_r        (mem_r),
    .i_m_r_valid  (mem_r_valid),
    .o_m_r_ready  (mem_r_ready)
  );

  axi_sram u_axi_sram (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_aw      (mem_aw),
    .i_aw_valid(mem_aw_valid),
    .o_aw_ready(mem_aw_ready),
    .i_w       (mem_w),
    .i_w_valid (mem_w_valid),
    .o_w_ready (mem_w_ready),
    .o_b       (mem_b),
    .o_b_valid (mem_b_valid),
    .i_b_ready (mem_b_ready),
    .i_ar      (mem_ar),
    .i_ar_valid(mem_ar_valid),
    .o_ar_ready(mem_ar_ready),
    .o_r       (mem_r),
    .o_r_valid (mem_r_valid),
    .i_r_ready (mem_r_ready)
  );

endmodule

// ==== tests/mem_subsys_properties.sv ====
`timescale 1ns/1ps

module mem_subsys_properties
  import axi_pkg::*;
(
  input logic    i_clk,
  input logic    i_rst_n,
  input axi_ar_t i_s0_ar,
  input logic    i_s0_ar_valid,
  input logic    i_s0_ar_ready,
  input axi_ar_t i_s1_ar,
  input logic    i_s1_ar_valid,
  input logic    i_s1_ar_ready,
  input logic    i_owner,
  input logic    i_busy,
  input axi_r_t  i_r,
  input logic    i_r_valid
);

  // A master that loses arbitration keeps its AR until granted
  s0_ar_stable: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_s0_ar_valid && !i_s0_ar_ready) |=> (i_s0_ar_valid && $stable(i_s0_ar))
  ) else $error("lsu AR payload or valid changed before ready");

  s1_ar_stable: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_s1_ar_valid && !i_s1_ar_ready) |=> (i_s1_ar_valid && $stable(i_s1_ar))
  ) else $error("ifu AR payload or valid changed before ready");

  // Read data belongs to the single owner of the read path
  r_to_owner: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_r_valid |-> (i_r.id[AXI_ID_W-1] == i_owner)
  ) else $error("R returned to a master that does not own the read path");

  r_in_busy: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_r_valid |-> i_busy
  ) else $error("R valid while the read path is free");

endmodule

bind axi_arbiter mem_subsys_properties u_properties (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_s0_ar      (i_s0_ar),
  .i_s0_ar_valid(i_s0_ar_valid),
  .i_s0_ar_ready(o_s0_ar_ready),
  .i_s1_ar      (i_s1_ar),
  .i_s1_ar_valid(i_s1_ar_valid),
  .i_s1_ar_ready(o_s1_ar_ready),
  .i_owner      (owner),
  .i_busy       (busy),
  .i_r          (i_m_r),
  .i_r_valid    (i_m_r_valid)
);

// ==== tests/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb
  import lsu_pkg::*;
();

  localparam int unsigned TIMEOUT_CYCLES = 200;

  typedef enum int {
    WAIT_LSU_READY,
    WAIT_LSU_POST,
    WAIT_FETCH_READY,
    WAIT_INSTR
  } wait_e;

  typedef struct packed {
    lsu_req_t req;
    lsu_rsp_t exp;
  } vector_t;

  logic                 clk;
  logic                 rst_n;
  lsu_req_t             lsu_req;
  logic                 lsu_valid;
  logic                 lsu_ready;
  lsu_rsp_t             lsu_rsp;
  logic                 lsu_post_valid;
  logic                 lsu_post_ready;
  logic [CPU_WIDTH-1:0] pc;
  logic                 fetch_valid;
  logic                 fetch_ready;
  logic [CPU_WIDTH-1:0] instr;
  logic                 instr_valid;
  logic                 instr_ready;

  integer               seed;
  vector_t              vectors[$];
  logic [CPU_WIDTH-1:0] shadow [MEM_DEPTH_WORDS];

  mem_subsys_top uut (
    .i_clk           (clk),
    .i_rst_n         (rst_n),
    .i_lsu_req       (lsu_req),
    .i_lsu_valid     (lsu_valid),
    .o_lsu_ready     (lsu_ready),
    .o_lsu_rsp       (lsu_rsp),
    .o_lsu_post_valid(lsu_post_valid),
    .i_lsu_post_ready(lsu_post_ready),
    .i_pc            (pc),
    .i_fetch_valid   (fetch_valid),
    .o_fetch_ready   (fetch_ready),
    .o_instr         (instr),
    .o_instr_valid   (instr_valid),
    .i_instr_ready   (instr_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_lsu_rsp(input lsu_rsp_t got, input lsu_rsp_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: lsu %s got %h, expected %h",
                          $time, what, got.data, exp.data));
    end
  endtask

  task automatic check_instr(input logic [CPU_WIDTH-1:0] got, input logic [CPU_WIDTH-1:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: fetch %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Outputs are sampled at the falling edge, where they have settled
  task automatic wait_signal(input wait_e sel, input string what);
    int unsigned n;
    logic        seen;
    n    = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      case (sel)
        WAIT_LSU_READY:   seen = lsu_ready;
        WAIT_LSU_POST:    seen = lsu_post_valid;
        WAIT_FETCH_READY: seen = fetch_ready;
        default:          seen = instr_valid;
      endcase
      n++;
      if (!seen && n >= TIMEOUT_CYCLES) begin
        abort_run({"timeout while waiting for ", what});
      end
    end
  endtask

  // Reference model of the byte lanes and load extension
  task automatic shadow_apply(input lsu_req_t req, output lsu_rsp_t rsp);
    int unsigned          idx;
    int unsigned          lane;
    int unsigned          nbytes;
    logic [CPU_WIDTH-1:0] val;
    idx  = (req.addr >> 2) % MEM_DEPTH_WORDS;
    lane = {30'd0, req.addr[1:0]};
    val  = '0;
    case (req.opt)
      LSU_LB, LSU_LBU, LSU_SB: nbytes = 1;
      LSU_LH, LSU_LHU, LSU_SH: nbytes = 2;
      default:                 nbytes = 4;
    endcase
    if (req.opt == LSU_NOP) begin
      val = '0;
    end else if (req.opt[0]) begin
      for (int b = 0; b < nbytes; b++) begin
        shadow[idx][8 * (lane + b) +: 8] = req.wdata[8 * b +: 8];
      end
    end else begin
      for (int b = 0; b < nbytes; b++) begin
        val[8 * b +: 8] = shadow[idx][8 * (lane + b) +: 8];
      end
      if (req.opt == LSU_LB || req.opt == LSU_LH) begin
        for (int b = nbytes; b < 4; b++) begin
          val[8 * b +: 8] = {8{val[8 * nbytes - 1]}};
        end
      end
    end
    rsp.data = val;
  endtask

  function automatic logic [CPU_WIDTH-1:0] word_pattern(input logic [CPU_WIDTH-1:0] addr);
    return (addr * 32'h0100_0193) ^ 32'hc0de_1a2b;
  endfunction

  task automatic add_vector(input lsu_op_e op, input logic [CPU_WIDTH-1:0] addr,
                            input logic [CPU_WIDTH-1:0] wdata);
    vector_t v;
    v.req.opt   = op;
    v.req.addr  = addr;
    v.req.wdata = wdata;
    shadow_apply(v.req, v.exp);
    vectors.push_back(v);
  endtask

  task automatic build_table();
    for (int w = 0; w < 16; w++) begin
      add_vector(LSU_SW, w * 4, word_pattern(w * 4));
      add_vector(LSU_LW, w * 4, '0);
    end
    add_vector(LSU_NOP, 32'h20, 32'hffff_ffff);
    add_vector(LSU_LW, 32'h20, '0);
    // Upper bits of store data are junk that the strobes must mask
    for (int l = 0; l < 4; l++) begin
      add_vector(LSU_SB, 32'h20 + l, (word_pattern(l) & ~32'hff) | (32'h80 + l * 32'h13));
      add_vector(LSU_SB, 32'h24 + l, (word_pattern(l) & ~32'hff) | (32'h11 + l * 32'h17));
    end
    for (int l = 0; l < 4; l += 2) begin
      add_vector(LSU_SH, 32'h28 + l, (word_pattern(l) & ~32'hffff) | (32'h8421 + l * 32'h1111));
      add_vector(LSU_SH, 32'h2c + l, (word_pattern(l) & ~32'hffff) | (32'h1357 + l * 32'h1010));
    end
    for (int w = 8; w < 12; w++) begin
      add_vector(LSU_LW, w * 4, '0);
    end
    for (int w = 8; w < 12; w++) begin
      for (int l = 0; l < 4; l++) begin
        add_vector(LSU_LB, w * 4 + l, '0);
        add_vector(LSU_LBU, w * 4 + l, '0);
        if (l % 2 == 0) begin
          add_vector(LSU_LH, w * 4 + l, '0);
          add_vector(LSU_LHU, w * 4 + l, '0);
        end
      end
    end
    add_vector(LSU_NOP, 32'h0, 32'h1234_5678);
    add_vector(LSU_LW, 32'h0, '0);
  endtask

  task automatic run_lsu(input vector_t v, input int unsigned hold, input string what);
    lsu_rsp_t first;
    @(posedge clk);
    lsu_req   <= v.req;
    lsu_valid <= 1'b1;
    wait_signal(WAIT_LSU_READY, {"lsu ready, ", what});
    @(posedge clk);
    lsu_valid <= 1'b0;
    wait_signal(WAIT_LSU_POST, {"lsu post valid, ", what});
    first = lsu_rsp;
    check_lsu_rsp(first, v.exp, what);
    repeat (hold) begin
      @(negedge clk);
      if (!lsu_post_valid) begin
        abort_run({"lsu response dropped before it was accepted, ", what});
      end
      if (lsu_ready) begin
        abort_run({"lsu ready rose while a response was pending, ", what});
      end
      check_lsu_rsp(lsu_rsp, first, {"held ", what});
    end
    @(posedge clk);
    lsu_post_ready <= 1'b1;
    @(posedge clk);
    lsu_post_ready <= 1'b0;
  endtask

  task automatic run_fetch(input logic [CPU_WIDTH-1:0] fpc, input int unsigned hold,
                           input string what);
    logic [CPU_WIDTH-1:0] exp;
    logic [CPU_WIDTH-1:0] first;
    exp = shadow[(fpc >> 2) % MEM_DEPTH_WORDS];
    @(posedge clk);
    pc          <= fpc;
    fetch_valid <= 1'b1;
    wait_signal(WAIT_FETCH_READY, {"fetch ready, ", what});
    @(posedge clk);
    fetch_valid <= 1'b0;
    wait_signal(WAIT_INSTR, {"instruction valid, ", what});
    first = instr;
    check_instr(first, exp, what);
    repeat (hold) begin
      @(negedge clk);
      if (!instr_valid || fetch_ready) begin
        abort_run({"fetch response not held under back-pressure, ", what});
      end
      check_instr(instr, first, {"held ", what});
    end
    @(posedge clk);
    instr_ready <= 1'b1;
    @(posedge clk);
    instr_ready <= 1'b0;
  endtask

  initial begin
    seed           = 32'h4dca9107;
    rst_n          <= 1'b0;
    lsu_req        <= '0;
    lsu_valid      <= 1'b0;
    lsu_post_ready <= 1'b0;
    pc             <= '0;
    fetch_valid    <= 1'b0;
    instr_ready    <= 1'b0;
    build_table();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (lsu_ready || fetch_ready || lsu_post_valid || instr_valid) begin
      abort_run("ready or valid output high in the first cycle after reset");
    end
    foreach (vectors[i]) begin
      run_lsu(vectors[i], $random(seed) & 3, $sformatf("entry %0d", i));
    end
    // Fetches race lsu loads for the shared read path
    fork
      begin
        logic [CPU_WIDTH-1:0] fpc;
        for (int k = 0; k < 12; k++) begin
          fpc = $random(seed) & 32'h3f;
          run_fetch(fpc, $random(seed) & 3, $sformatf("fetch %0d at %h", k, fpc));
        end
      end
      begin
        vector_t v;
        for (int k = 0; k < 12; k++) begin
          v.req.opt   = LSU_LW;
          v.req.addr  = ((k * 5) % 16) * 4;
          v.req.wdata = '0;
          shadow_apply(v.req, v.exp);
          run_lsu(v, $random(seed) & 3, $sformatf("concurrent load %0d", k));
        end
      end
    join
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== all.f ====
src/axi_pkg.sv
src/lsu_pkg.sv
src/lsu.sv
src/ifu.sv
src/axi_arbiter.sv
src/axi_sram.sv
src/mem_subsys_top.sv
tests/mem_subsys_properties.sv
tests/mem_subsys_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mem_subsys_tb
RTL_TOP    := mem_subsys_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
